//--- design/router_pkg.sv
// router package: packet and port types, FSM state enums and the
// destination lookup shared by the four-port router
`default_nettype none

package router_pkg;

  localparam int num_ports     = 4;
  localparam int bytes_per_pkt = 4;

  typedef logic [3:0] node_id_t;
  typedef logic [1:0] port_idx_t;
  typedef logic [3:0] port_mask_t;

  // dest_id sits in the most significant byte, so it is the first byte on the wire
  typedef struct packed {
    node_id_t    dest_id;
    node_id_t    src_id;
    logic [23:0] payload;
  } pkt_t;

  // names the input port feeding one output
  typedef struct packed {
    logic      valid;
    port_idx_t src;
  } xfer_t;

  typedef enum logic [1:0] {
    ingress_idle,
    ingress_load,
    ingress_hold
  } ingress_state_e;

  typedef enum logic {
    egress_idle,
    egress_send
  } egress_state_e;

  // router 0 serves nodes 0-2 with port 1 as uplink, router 1 serves nodes 3-5
  // with port 3 as uplink
  function automatic port_idx_t route_port(input int unsigned router_id,
                                           input node_id_t node_id);
    port_idx_t out_port;
    if (router_id == 0) begin
      case (node_id)
        4'd0:    out_port = 2'd0;
        4'd1:    out_port = 2'd2;
        4'd2:    out_port = 2'd3;
        default: out_port = 2'd1;
      endcase
    end else begin
      case (node_id)
        4'd3:    out_port = 2'd0;
        4'd4:    out_port = 2'd1;
        4'd5:    out_port = 2'd2;
        default: out_port = 2'd3;
      endcase
    end
    return out_port;
  endfunction

endpackage

`default_nettype wire

//--- design/ingress_port.sv
// ingress port: collects four inbound bytes into a packet and keeps it
// until an output register has taken it
`timescale 1ns/1ps
`default_nettype none

module ingress_port (
  input  logic             clk,
  input  logic             rst_b,
  input  logic             put_inbound,
  input  logic             release_pkt,
  input  logic [7:0]       payload_inbound,
  output logic             free_inbound,
  output logic             avail,
  output router_pkg::pkt_t pkt
);
  import router_pkg::*;

  localparam int cnt_w = $clog2(bytes_per_pkt);

  ingress_state_e   state;
  ingress_state_e   state_next;
  logic [cnt_w-1:0] byte_cnt;
  logic             shift_en;

  always_comb begin
    state_next = state;
    shift_en   = 1'b0;
    case (state)
      ingress_idle: begin
        if (put_inbound) begin
          shift_en   = 1'b1;
          state_next = ingress_load;
        end
      end
      ingress_load: begin
        shift_en = 1'b1;
        if (byte_cnt == cnt_w'(bytes_per_pkt - 1)) begin
          state_next = ingress_hold;
        end
      end
      ingress_hold: begin
        if (release_pkt) begin
          state_next = ingress_idle;
        end
      end
      default: state_next = ingress_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      state        <= ingress_idle;
      byte_cnt     <= '0;
      free_inbound <= 1'b1;
    end else begin
      state <= state_next;
      // the counter wraps back to zero on the last byte
      byte_cnt <= shift_en ? byte_cnt + 1'b1 : '0;
      // sender sees free drop right after its first byte
      free_inbound <= (state_next == ingress_idle);
    end
  end

  // most significant byte arrives first and ends up on top
  always_ff @(posedge clk) begin
    if (shift_en) begin
      pkt <= pkt_t'({pkt[23:0], payload_inbound});
    end
  end

  assign avail = (state == ingress_hold);

endmodule

`default_nettype wire

//--- design/route_allocator.sv
// route allocator: looks up the output of every waiting packet and runs one
// round-robin arbiter per output so that distinct outputs grant in parallel
`timescale 1ns/1ps
`default_nettype none

module route_allocator #(
  parameter int unsigned router_id = 0
) (
  input  logic                                         clk,
  input  logic                                         rst_b,
  input  router_pkg::port_mask_t                       avail,
  input  router_pkg::pkt_t [router_pkg::num_ports-1:0] pkt,
  input  router_pkg::port_mask_t                       release_mask,
  output router_pkg::xfer_t [router_pkg::num_ports-1:0] grant
);
  import router_pkg::*;

  port_mask_t                  queued;
  port_mask_t                  req;
  port_mask_t                  granted;
  port_idx_t [num_ports-1:0]   dest_port;
  port_idx_t [num_ports-1:0]   rr_ptr;

  always_comb begin
    for (int i = 0; i < num_ports; i++) begin
      dest_port[i] = route_port(router_id, pkt[i].dest_id);
    end
  end

  // a packet already sitting in an output queue must not ask again
  assign req = avail & ~queued;

  always_comb begin : arbiter
    port_idx_t cand;
    grant = '0;
    for (int o = 0; o < num_ports; o++) begin
      // search upward from the pointer, the index wraps at the port count
      for (int k = 0; k < num_ports; k++) begin
        cand = port_idx_t'(rr_ptr[o] + k);
        if (!grant[o].valid && req[cand] && dest_port[cand] == port_idx_t'(o)) begin
          grant[o].valid = 1'b1;
          grant[o].src   = cand;
        end
      end
    end
  end

  // each input routes to exactly one output, so it is granted at most once
  always_comb begin
    granted = '0;
    for (int o = 0; o < num_ports; o++) begin
      if (grant[o].valid) begin
        granted[grant[o].src] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      queued <= '0;
      rr_ptr <= '0;
    end else begin
      queued <= (queued | granted) & ~release_mask;
      for (int o = 0; o < num_ports; o++) begin
        if (grant[o].valid) begin
          rr_ptr[o] <= grant[o].src + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- design/egress_queue.sv
// egress queue: keeps granted source ports for one output in arrival order
// and loads the output register whenever it is empty
`timescale 1ns/1ps
`default_nettype none

module egress_queue (
  input  logic                   clk,
  input  logic                   rst_b,
  input  router_pkg::xfer_t      grant,
  input  logic                   empty,
  output router_pkg::xfer_t      load,
  output router_pkg::port_mask_t release_mask
);
  import router_pkg::*;

  // one slot per input is enough since an input waits in one queue at most
  localparam int depth = num_ports;
  localparam int ptr_w = $clog2(depth);
  localparam int cnt_w = $clog2(depth + 1);

  port_idx_t [depth-1:0] fifo;
  logic [ptr_w-1:0]      first;
  logic [ptr_w-1:0]      last;
  logic [cnt_w-1:0]      count;
  logic                  push;
  logic                  pop;

  assign push = grant.valid;

  // count is registered, so a new grant can be loaded one cycle later at the earliest
  assign pop = (count != '0) && empty;

  assign load = '{valid: pop, src: fifo[first]};

  // the source is freed in the same cycle its packet is copied out
  always_comb begin
    release_mask = '0;
    if (pop) begin
      release_mask[fifo[first]] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      fifo[last] <= grant.src;
    end
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      first <= '0;
      last  <= '0;
      count <= '0;
    end else begin
      if (push) begin
        last <= last + 1'b1;
      end
      if (pop) begin
        first <= first + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- design/egress_port.sv
// egress port: holds one packet and sends it as four bytes, most
// significant first, once the receiver shows free
`timescale 1ns/1ps
`default_nettype none

module egress_port (
  input  logic             clk,
  input  logic             rst_b,
  input  logic             wr,
  input  logic             free_outbound,
  input  router_pkg::pkt_t pkt_in,
  output logic             put_outbound,
  output logic             empty,
  output logic [7:0]       payload_outbound
);
  import router_pkg::*;

  localparam int sel_w = $clog2(bytes_per_pkt);

  egress_state_e                    state;
  egress_state_e                    state_next;
  logic [bytes_per_pkt-1:0][7:0]    data_q;
  logic [sel_w-1:0]                 sel;
  logic                             last_byte;

  assign last_byte = (state == egress_send) && (sel == sel_w'(bytes_per_pkt - 1));

  always_comb begin
    state_next = state;
    case (state)
      egress_idle: begin
        if (free_outbound && !empty) begin
          state_next = egress_send;
        end
      end
      egress_send: begin
        if (last_byte) begin
          state_next = egress_idle;
        end
      end
      default: state_next = egress_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      state        <= egress_idle;
      sel          <= '0;
      empty        <= 1'b1;
      put_outbound <= 1'b0;
    end else begin
      state        <= state_next;
      put_outbound <= (state_next == egress_send);
      sel          <= (state == egress_send) ? sel + 1'b1 : '0;
      // the queue only writes while empty is high, so the two never meet
      if (last_byte) begin
        empty <= 1'b1;
      end else if (wr) begin
        empty <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr) begin
      data_q <= pkt_in;
    end
  end

  assign payload_outbound = data_q[bytes_per_pkt - 1 - sel];

endmodule

`default_nettype wire

//--- design/router.sv
// four-port packet router: ingress buffers, per-output round-robin
// allocation, output queues and byte-serial egress links
`timescale 1ns/1ps
`default_nettype none

module router #(
  parameter int unsigned router_id = 0
) (
  input  logic                                   clk,
  input  logic                                   rst_b,
  output router_pkg::port_mask_t                 free_inbound,
  input  router_pkg::port_mask_t                 put_inbound,
  input  logic [router_pkg::num_ports-1:0][7:0]  payload_inbound,
  input  router_pkg::port_mask_t                 free_outbound,
  output router_pkg::port_mask_t                 put_outbound,
  output logic [router_pkg::num_ports-1:0][7:0]  payload_outbound
);
  import router_pkg::*;

  pkt_t [num_ports-1:0]       in_pkt;
  pkt_t [num_ports-1:0]       out_pkt;
  port_mask_t                 avail;
  port_mask_t                 empty;
  port_mask_t                 release_all;
  port_mask_t [num_ports-1:0] release_mask;
  xfer_t [num_ports-1:0]      grant;
  xfer_t [num_ports-1:0]      load;

  // every source is owned by one queue at a time, so the masks never overlap
  always_comb begin
    release_all = '0;
    for (int o = 0; o < num_ports; o++) begin
      release_all |= release_mask[o];
    end
  end

  route_allocator #(
    .router_id(router_id)
  ) u_alloc (
    .clk         (clk),
    .rst_b       (rst_b),
    .avail       (avail),
    .pkt         (in_pkt),
    .release_mask(release_all),
    .grant       (grant)
  );

  for (genvar p = 0; p < num_ports; p++) begin : g_port
    ingress_port u_ingress (
      .clk            (clk),
      .rst_b          (rst_b),
      .put_inbound    (put_inbound[p]),
      .release_pkt    (release_all[p]),
      .payload_inbound(payload_inbound[p]),
      .free_inbound   (free_inbound[p]),
      .avail          (avail[p]),
      .pkt            (in_pkt[p])
    );

    egress_queue u_queue (
      .clk         (clk),
      .rst_b       (rst_b),
      .grant       (grant[p]),
      .empty       (empty[p]),
      .load        (load[p]),
      .release_mask(release_mask[p])
    );

    // packet path from the ingress buffer named by this output's load
    assign out_pkt[p] = in_pkt[load[p].src];

    egress_port u_egress (
      .clk             (clk),
      .rst_b           (rst_b),
      .wr              (load[p].valid),
      .free_outbound   (free_outbound[p]),
      .pkt_in          (out_pkt[p]),
      .put_outbound    (put_outbound[p]),
      .empty           (empty[p]),
      .payload_outbound(payload_outbound[p])
    );
  end

endmodule

`default_nettype wire

//--- dv/router_tb.sv
// directed testbench for router 0 that checks reset, routing, concurrency,
// round-robin fairness and output back-pressure
`timescale 1ns/1ps
`default_nettype none

module router_tb;
  import router_pkg::*;

  localparam int clk_period = 20;
  localparam int num_tests  = 5;
  localparam int exp_depth  = 16;

  logic                      clk;
  logic                      rst_b;
  port_mask_t                free_inbound;
  port_mask_t                put_inbound;
  logic [num_ports-1:0][7:0] payload_inbound;
  port_mask_t                free_outbound;
  port_mask_t                put_outbound;
  logic [num_ports-1:0][7:0] payload_outbound;

  // expected packets per output are kept in delivery order
  logic [31:0] exp_pkt [num_ports][exp_depth];
  int          exp_wr  [num_ports];
  int          exp_rd  [num_ports];
  int          mismatch_cnt;
  int          fail_cnt;
  int unsigned seed;

  router #(
    .router_id(0)
  ) u_router (
    .clk             (clk),
    .rst_b           (rst_b),
    .free_inbound    (free_inbound),
    .put_inbound     (put_inbound),
    .payload_inbound (payload_inbound),
    .free_outbound   (free_outbound),
    .put_outbound    (put_outbound),
    .payload_outbound(payload_outbound)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    #(num_tests * 200 * clk_period);
    fail_cnt++;
    $display("timeout: the tests did not finish within %0d cycles", num_tests * 200);
    $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
    $display("Done: errors found");
    $finish;
  end

  // router 0 keeps nodes 0, 1 and 2 on ports 0, 2 and 3 and sends the rest to its uplink
  function automatic int out_port_for(input logic [3:0] dest);
    case (dest)
      4'd0:    return 0;
      4'd1:    return 2;
      4'd2:    return 3;
      default: return 1;
    endcase
  endfunction

  function automatic logic [31:0] make_pkt(input logic [3:0] dest, input logic [3:0] src);
    return {dest, src, 24'($urandom)};
  endfunction

  task automatic expect_pkt(input logic [31:0] pkt);
    int p;
    p = out_port_for(pkt[31:28]);
    exp_pkt[p][exp_wr[p] % exp_depth] = pkt;
    exp_wr[p]++;
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst_b <= 1'b0;
    repeat (4) @(posedge clk);
    rst_b <= 1'b1;
  endtask

  // the sender may start only while free is high, then holds put for four cycles
  task automatic send_pkt(input int p, input logic [31:0] pkt);
    @(negedge clk);
    while (!free_inbound[p]) begin
      @(negedge clk);
    end
    @(posedge clk);
    put_inbound[p]     <= 1'b1;
    payload_inbound[p] <= pkt[31:24];
    for (int b = 2; b >= 0; b--) begin
      @(posedge clk);
      payload_inbound[p] <= pkt[b*8 +: 8];
    end
    @(posedge clk);
    put_inbound[p] <= 1'b0;
  endtask

  task automatic collect_pkts(input int p);
    logic [31:0] got;
    logic [31:0] exp;
    int          n;
    forever begin
      @(negedge clk);
      if (put_outbound[p]) begin
        got = '0;
        n   = 0;
        while (n < bytes_per_pkt && put_outbound[p]) begin
          got = {got[23:0], payload_outbound[p]};
          n++;
          if (n < bytes_per_pkt) begin
            @(negedge clk);
          end
        end
        if (n < bytes_per_pkt) begin
          fail_cnt++;
          $display("put_outbound[%0d] went low after %0d bytes at %0t", p, n, $time);
        end else if (exp_rd[p] == exp_wr[p]) begin
          fail_cnt++;
          $display("port %0d delivered packet %h that nobody sent to it at %0t", p, got, $time);
        end else begin
          exp = exp_pkt[p][exp_rd[p] % exp_depth];
          exp_rd[p]++;
          if (got !== exp) begin
            mismatch_cnt++;
            $display("mismatch at %0t: payload_outbound[%0d] expected %h got %h",
                     $time, p, exp, got);
          end
        end
      end
    end
  endtask

  task automatic wait_drain();
    int pending;
    pending = 1;
    while (pending != 0) begin
      @(negedge clk);
      pending = 0;
      for (int p = 0; p < num_ports; p++) begin
        pending += exp_wr[p] - exp_rd[p];
      end
    end
    // a few idle cycles catch packets delivered twice
    repeat (10) @(negedge clk);
  endtask

  task automatic test_reset();
    @(negedge clk);
    if (free_inbound !== 4'hf) begin
      mismatch_cnt++;
      $display("mismatch at %0t: free_inbound expected f got %h", $time, free_inbound);
    end
    if (put_outbound !== 4'h0) begin
      mismatch_cnt++;
      $display("mismatch at %0t: put_outbound expected 0 got %h", $time, put_outbound);
    end
  endtask

  task automatic test_routing();
    logic [31:0] pkt;
    for (int d = 0; d < 6; d++) begin
      pkt = make_pkt(4'(d), 4'd0);
      expect_pkt(pkt);
      send_pkt(0, pkt);
    end
    wait_drain();
  endtask

  task automatic test_concurrency();
    logic [31:0] pkts [num_ports];
    pkts[0] = make_pkt(4'd1, 4'd0);
    pkts[1] = make_pkt(4'd2, 4'd1);
    pkts[2] = make_pkt(4'd0, 4'd2);
    pkts[3] = make_pkt(4'd4, 4'd3);
    for (int i = 0; i < num_ports; i++) begin
      expect_pkt(pkts[i]);
    end
    fork
      send_pkt(0, pkts[0]);
      send_pkt(1, pkts[1]);
      send_pkt(2, pkts[2]);
      send_pkt(3, pkts[3]);
    join
    wait_drain();
  endtask

  // all three requests meet at once, so the port 3 pointer starting at 0 picks 0, 2, 3
  task automatic test_fairness();
    logic [31:0] pkts [num_ports];
    apply_reset();
    pkts[0] = make_pkt(4'd2, 4'd0);
    pkts[2] = make_pkt(4'd2, 4'd2);
    pkts[3] = make_pkt(4'd2, 4'd3);
    expect_pkt(pkts[0]);
    expect_pkt(pkts[2]);
    expect_pkt(pkts[3]);
    fork
      send_pkt(3, pkts[3]);
      send_pkt(0, pkts[0]);
      send_pkt(2, pkts[2]);
    join
    wait_drain();
    // a lone packet from input 2 moves the pointer to 3, so input 3 now wins over input 0
    pkts[2] = make_pkt(4'd2, 4'd2);
    pkts[3] = make_pkt(4'd2, 4'd3);
    pkts[0] = make_pkt(4'd2, 4'd0);
    expect_pkt(pkts[2]);
    expect_pkt(pkts[3]);
    expect_pkt(pkts[0]);
    send_pkt(2, pkts[2]);
    fork
      send_pkt(3, pkts[3]);
      send_pkt(0, pkts[0]);
    join
    wait_drain();
  endtask

  task automatic test_backpressure();
    logic [31:0] first_pkt;
    logic [31:0] second_pkt;
    @(posedge clk);
    free_outbound[2] <= 1'b0;
    first_pkt  = make_pkt(4'd1, 4'd0);
    second_pkt = make_pkt(4'd1, 4'd1);
    expect_pkt(first_pkt);
    expect_pkt(second_pkt);
    send_pkt(0, first_pkt);
    send_pkt(1, second_pkt);
    repeat (20) begin
      @(negedge clk);
      if (put_outbound[2]) begin
        fail_cnt++;
        $display("port 2 started sending while its receiver was not free at %0t", $time);
      end
      if (free_inbound[1] !== 1'b0) begin
        mismatch_cnt++;
        $display("mismatch at %0t: free_inbound[1] expected 0 got %b", $time, free_inbound[1]);
      end
    end
    @(posedge clk);
    free_outbound[2] <= 1'b1;
    wait_drain();
  endtask

  initial begin
    fork
      collect_pkts(0);
      collect_pkts(1);
      collect_pkts(2);
      collect_pkts(3);
    join_none
  end

  initial begin
    seed = 32'haa2e4008;
    void'($urandom(seed));
    mismatch_cnt = 0;
    fail_cnt     = 0;
    for (int p = 0; p < num_ports; p++) begin
      exp_wr[p] = 0;
      exp_rd[p] = 0;
    end
    rst_b           <= 1'b0;
    put_inbound     <= '0;
    payload_inbound <= '0;
    free_outbound   <= '1;
    apply_reset();
    test_reset();
    test_routing();
    test_concurrency();
    test_fairness();
    test_backpressure();
    $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
    if (mismatch_cnt + fail_cnt == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
design/router_pkg.sv
design/ingress_port.sv
design/route_allocator.sv
design/egress_queue.sv
design/egress_port.sv
design/router.sv
dv/router_tb.sv

//--- Bender.yml
package:
  name: router

sources:
  - design/router_pkg.sv
  - design/ingress_port.sv
  - design/route_allocator.sv
  - design/egress_queue.sv
  - design/egress_port.sv
  - design/router.sv
  - target: test
    files:
      - dv/router_tb.sv
